/* logic/phy_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, addresses and the start-up state encoding shared by the
// DDR3 PHY control plane.
// The address group field sits above DLY_GROUP_LSB, so one group
// holds 2**DLY_GROUP_LSB delays.
// PS_ADDR lies in group 3 and never lands in a three-group bank.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package phy_ctrl_pkg;

    // delay and phase data, 3 LSB are the fine part of a delay
    localparam int DLY_DATA_W = 8;

    // delay programming address
    localparam int DLY_ADDR_W = 7;

    localparam int DLY_GROUP_LSB = 5;                     // group field is addr[6:5]
    localparam int DLY_PER_GROUP = 2 ** DLY_GROUP_LSB;    // 32 delays per group

    typedef logic [DLY_DATA_W-1:0] dly_data_t;
    typedef logic [DLY_ADDR_W-1:0] dly_addr_t;

    // phase shift target register
    localparam dly_addr_t PS_ADDR = 7'h60;

    // start-up sequence, locked only in ST_READY
    typedef enum logic [1:0] {
        ST_RESET     = 2'd0,    // held in reset
        ST_LOCK_WAIT = 2'd1,    // modelled clock lock time
        ST_CAL       = 2'd2,    // modelled delay and DCI calibration
        ST_READY     = 2'd3     // all ready, locked high
    } startup_state_e;

endpackage : phy_ctrl_pkg

`default_nettype wire

/* logic/dly_prog_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Delay programming bundle in the clk_div domain.
// ld_delay and set are one-cycle strobes with no handshake.
// The phase consumer does not see set.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface dly_prog_if import phy_ctrl_pkg::*; ();

    dly_data_t dly_data;    // delay value or phase target
    dly_addr_t dly_addr;    // group and index of the delay
    logic      ld_delay;    // write dly_data to the pending entry
    logic      set;         // copy all pending entries to active

    modport src (
        output dly_data, dly_addr, ld_delay, set
    );

    modport bank (
        input dly_data, dly_addr, ld_delay, set
    );

    modport phase (
        input dly_data, dly_addr, ld_delay
    );

endinterface : dly_prog_if

`default_nettype wire

/* logic/delay_bank.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Staged I/O delay registers for NUM_GROUPS groups.
// A ld_delay and a set in the same cycle put the new value in
// pending only; set copies the values held before that edge.
// Read-back lags its address by one cycle, groups past
// NUM_GROUPS write nothing and read zero.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module delay_bank
    import phy_ctrl_pkg::*;
#(
    parameter int NUM_GROUPS = 3
) (
    input  logic       clk_div_i,
    input  logic       rst_i,
    dly_prog_if.bank   prog,
    input  dly_addr_t  dly_rd_addr_i,
    output dly_data_t  dly_rd_o
);

    localparam int NUM_DLY = NUM_GROUPS * DLY_PER_GROUP;

    dly_data_t pend_q [NUM_DLY];    // staged values from ld_delay
    dly_data_t act_q  [NUM_DLY];    // values in use by the pins
    logic      ld_hit;              // load targets an existing group
    logic      rd_hit;              // read address inside the bank

    // group number of an address
    function automatic int dly_group(dly_addr_t addr);
        return int'(addr[DLY_ADDR_W-1:DLY_GROUP_LSB]);
    endfunction

    // flat entry number, group-major
    function automatic int dly_index(dly_addr_t addr);
        int idx;
        idx = int'(addr[DLY_GROUP_LSB-1:0]);
        return dly_group(addr) * DLY_PER_GROUP + idx;
    endfunction

    assign ld_hit = prog.ld_delay && (dly_group(prog.dly_addr) < NUM_GROUPS);
    assign rd_hit = dly_group(dly_rd_addr_i) < NUM_GROUPS;

    always_ff @(posedge clk_div_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_DLY; i++) begin
                pend_q[i] <= '0;
                act_q[i]  <= '0;
            end
        end else begin
            if (ld_hit) begin
                pend_q[dly_index(prog.dly_addr)] <= prog.dly_data;    // stage one delay
            end
            if (prog.set) begin
                for (int i = 0; i < NUM_DLY; i++) begin
                    act_q[i] <= pend_q[i];    // whole set switches together
                end
            end
        end
    end

    // registered read-back of the active set
    always_ff @(posedge clk_div_i) begin
        if (rst_i) begin
            dly_rd_o <= '0;
        end else if (rd_hit) begin
            dly_rd_o <= act_q[dly_index(dly_rd_addr_i)];
        end else begin
            dly_rd_o <= '0;    // unused group
        end
    end

endmodule : delay_bank

`default_nettype wire

/* logic/phase_shift_cntr.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phase stepping toward a signed target, one step every
// PS_STEP_CYCLES clocks, like a clock generator fine shift.
// Loads are taken only while ps_rdy_o is high; others are dropped.
// ps_rdy_o rises on the edge the phase reaches the target.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module phase_shift_cntr
    import phy_ctrl_pkg::*;
#(
    parameter int PHASE_WIDTH    = 8,
    parameter int PS_STEP_CYCLES = 12
) (
    input  logic                   clk_div_i,
    input  logic                   rst_i,
    dly_prog_if.phase              prog,
    output logic                   ps_rdy_o,
    output logic [PHASE_WIDTH-1:0] ps_out_o
);

    localparam int STEP_W = $clog2(PS_STEP_CYCLES + 1);

    logic signed [PHASE_WIDTH-1:0] target_q;     // requested phase
    logic signed [PHASE_WIDTH-1:0] phase_q;      // phase applied now
    logic signed [PHASE_WIDTH-1:0] target_d;     // dly_data as signed phase
    logic signed [PHASE_WIDTH-1:0] phase_nxt;    // phase after one step
    logic        [STEP_W-1:0]      step_q;       // clocks left until next step
    logic                          ps_ld;        // write to the phase register

    assign ps_ld    = prog.ld_delay && (prog.dly_addr == PS_ADDR);
    assign target_d = PHASE_WIDTH'(signed'(prog.dly_data));    // sign extend

    // one step up or down, signed compare
    always_comb begin
        if (target_q > phase_q) begin
            phase_nxt = phase_q + 1'b1;
        end else begin
            phase_nxt = phase_q - 1'b1;
        end
    end

    always_ff @(posedge clk_div_i) begin
        if (rst_i) begin
            target_q <= '0;
            phase_q  <= '0;
            step_q   <= '0;
            ps_rdy_o <= 1'b1;
        end else if (ps_rdy_o) begin
            if (ps_ld) begin
                target_q <= target_d;
                if (target_d != phase_q) begin
                    ps_rdy_o <= 1'b0;                          // start the move
                    step_q   <= STEP_W'(PS_STEP_CYCLES - 1);
                end
            end
        end else if (step_q == '0) begin
            phase_q <= phase_nxt;
            step_q  <= STEP_W'(PS_STEP_CYCLES - 1);
            if (phase_nxt == target_q) begin
                ps_rdy_o <= 1'b1;    // ready together with the last step
            end
        end else begin
            step_q <= step_q - 1'b1;
        end
    end

    assign ps_out_o = phase_q;

endmodule : phase_shift_cntr

`default_nettype wire

/* logic/startup_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start-up sequence with modelled lock and calibration times.
// After rst_i falls: LOCK_CYCLES in ST_LOCK_WAIT, CAL_CYCLES in
// ST_CAL, then ST_READY with locked_o high.
// dly_rst_i or dci_rst_i in ST_CAL or ST_READY restarts
// calibration; in ST_LOCK_WAIT they are ignored.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module startup_fsm
    import phy_ctrl_pkg::*;
#(
    parameter int LOCK_CYCLES = 64,
    parameter int CAL_CYCLES  = 32
) (
    input  logic clk_div_i,
    input  logic rst_i,
    input  logic dly_rst_i,
    input  logic dci_rst_i,
    output logic locked_o
);

    localparam int MAX_WAIT = (LOCK_CYCLES > CAL_CYCLES) ? LOCK_CYCLES : CAL_CYCLES;
    localparam int WAIT_W   = $clog2(MAX_WAIT) + 1;

    startup_state_e      state_q;
    logic [WAIT_W-1:0]   wait_q;     // cycles left in the current state
    logic                recal;      // calibration restart request
    logic                wait_done;

    assign recal     = dly_rst_i || dci_rst_i;
    assign wait_done = (wait_q == '0);

    always_ff @(posedge clk_div_i) begin
        if (rst_i) begin
            state_q <= ST_RESET;
            wait_q  <= '0;
        end else begin
            unique case (state_q)
                ST_RESET: begin
                    state_q <= ST_LOCK_WAIT;                  // first cycle out of reset
                    wait_q  <= WAIT_W'(LOCK_CYCLES - 1);
                end
                ST_LOCK_WAIT: begin
                    if (wait_done) begin
                        state_q <= ST_CAL;
                        wait_q  <= WAIT_W'(CAL_CYCLES - 1);
                    end else begin
                        wait_q <= wait_q - 1'b1;
                    end
                end
                ST_CAL: begin
                    if (recal) begin
                        wait_q <= WAIT_W'(CAL_CYCLES - 1);    // fresh count
                    end else if (wait_done) begin
                        state_q <= ST_READY;
                    end else begin
                        wait_q <= wait_q - 1'b1;
                    end
                end
                ST_READY: begin
                    if (recal) begin
                        state_q <= ST_CAL;    // drops locked at once
                        wait_q  <= WAIT_W'(CAL_CYCLES - 1);
                    end
                end
                default: begin
                    state_q <= ST_RESET;
                    wait_q  <= '0;
                end
            endcase
        end
    end

    // stands in for pll, delay ctrl and dci ready all high
    assign locked_o = (state_q == ST_READY);

endmodule : startup_fsm

`default_nettype wire

/* logic/ddr3_phy_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control plane of the DDR3 PHY, all in the clk_div domain.
// No clocking, I/O buffers or serdes paths; lock and calibration
// are fixed modelled times.
// rst_in is registered once, so every block sees reset a cycle
// late. locked_o rises LOCK_CYCLES+CAL_CYCLES+2 edges after rst_in
// goes low, counting the edge that samples it as the first.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ddr3_phy_ctrl
    import phy_ctrl_pkg::*;
#(
    parameter int NUM_GROUPS     = 3,     // low lane, high lane, cmd/addr
    parameter int PHASE_WIDTH    = 8,
    parameter int PS_STEP_CYCLES = 12,    // clocks per phase step
    parameter int LOCK_CYCLES    = 64,    // modelled clock lock time
    parameter int CAL_CYCLES     = 32     // modelled calibration time
) (
    input  logic                   clk_div_i,        // control clock
    input  logic                   rst_in,           // sync reset, active high
    input  logic                   ddr_rst_i,        // memory reset request
    input  logic                   dly_rst_i,        // restart delay calibration
    input  logic                   dci_rst_i,        // restart dci calibration
    input  dly_data_t              dly_data_i,       // delay or phase value
    input  dly_addr_t              dly_addr_i,       // delay select
    input  logic                   ld_delay_i,       // load strobe
    input  logic                   set_i,            // apply all pending delays
    input  dly_addr_t              dly_rd_addr_i,    // read-back select
    output logic                   ddr3_nrst_o,      // memory reset pin, active low
    output logic                   locked_o,         // clocks and calibration ready
    output logic                   ps_rdy_o,         // phase shift idle
    output logic [PHASE_WIDTH-1:0] ps_out_o,         // current phase
    output dly_data_t              dly_rd_o          // active delay read-back
);

    logic rst;    // registered reset for all blocks

    always_ff @(posedge clk_div_i) begin
        rst <= rst_in;
    end

    dly_prog_if prog ();

    assign prog.dly_data = dly_data_i;
    assign prog.dly_addr = dly_addr_i;
    assign prog.ld_delay = ld_delay_i;
    assign prog.set      = set_i;

    // memory reset pin is a plain inversion
    assign ddr3_nrst_o = ~ddr_rst_i;

    delay_bank #(
        .NUM_GROUPS    (NUM_GROUPS)
    ) delay_bank_i (
        .clk_div_i     (clk_div_i),
        .rst_i         (rst),
        .prog          (prog.bank),
        .dly_rd_addr_i (dly_rd_addr_i),
        .dly_rd_o      (dly_rd_o)
    );

    phase_shift_cntr #(
        .PHASE_WIDTH    (PHASE_WIDTH),
        .PS_STEP_CYCLES (PS_STEP_CYCLES)
    ) phase_shift_cntr_i (
        .clk_div_i      (clk_div_i),
        .rst_i          (rst),
        .prog           (prog.phase),
        .ps_rdy_o       (ps_rdy_o),
        .ps_out_o       (ps_out_o)
    );

    startup_fsm #(
        .LOCK_CYCLES (LOCK_CYCLES),
        .CAL_CYCLES  (CAL_CYCLES)
    ) startup_fsm_i (
        .clk_div_i   (clk_div_i),
        .rst_i       (rst),
        .dly_rst_i   (dly_rst_i),
        .dci_rst_i   (dci_rst_i),
        .locked_o    (locked_o)
    );

endmodule : ddr3_phy_ctrl

`default_nettype wire

/* verif/phy_ctrl_asserts.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checks on the DDR3 PHY control outputs, bound into
// ddr3_phy_ctrl and clocked by clk_div_i.
// rst_i is the registered reset inside the top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module phy_ctrl_asserts #(
    parameter int PHASE_WIDTH = 8
) (
    input logic                   clk_div_i,
    input logic                   rst_i,
    input logic                   locked_i,
    input logic                   ps_rdy_i,
    input logic [PHASE_WIDTH-1:0] ps_out_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // second reset cycle onward, state is ST_RESET
    locked_in_reset: assert property (@(posedge clk_div_i)
        (rst_i && $past(rst_i)) |-> !locked_i)
        else $error("locked_o high while reset is active");

    // phase counter idle right after reset
    rdy_after_reset: assert property (@(posedge clk_div_i)
        $fell(rst_i) |-> ps_rdy_i)
        else $error("ps_rdy_o low in the first cycle after reset");

    // one phase step at most per clock
    phase_single_step: assert property (@(posedge clk_div_i) disable iff (rst_i)
        (ps_out_i == $past(ps_out_i)) ||
        ((ps_out_i - $past(ps_out_i)) == PHASE_WIDTH'(1)) ||
        (($past(ps_out_i) - ps_out_i) == PHASE_WIDTH'(1)))
        else $error("ps_out_o moved by more than one step");

endmodule : phy_ctrl_asserts

bind ddr3_phy_ctrl phy_ctrl_asserts #(
    .PHASE_WIDTH (PHASE_WIDTH)
) asserts_i (
    .clk_div_i   (clk_div_i),
    .rst_i       (rst),
    .locked_i    (locked_o),
    .ps_rdy_i    (ps_rdy_o),
    .ps_out_i    (ps_out_o)
);

`default_nettype wire

/* verif/tb_ddr3_phy_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for ddr3_phy_ctrl against a model of the delay bank,
// the phase target and the start-up timing.
// Inputs change 2 ns after the rising edge, outputs are sampled
// there too. Phase targets stay within +-20 so moves are bounded.
// Addresses hitting PS_ADDR are moved off it in the bank test.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_ddr3_phy_ctrl import phy_ctrl_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_GROUPS     = 3;
    localparam int PHASE_WIDTH    = 8;
    localparam int PS_STEP_CYCLES = 12;
    localparam int LOCK_CYCLES    = 64;
    localparam int CAL_CYCLES     = 32;
    localparam int CLK_PERIOD     = 40;
    localparam int RST_CYCLES     = 8;
    localparam int RAND_CYCLES    = 300;
    localparam int NUM_PS_MOVES   = 8;
    localparam int PS_MOVE_LIMIT  = 40 * PS_STEP_CYCLES + 4;    // widest move is 40 steps
    localparam int NRST_CYCLES    = 50;
    localparam int NUM_DLY        = NUM_GROUPS * DLY_PER_GROUP;
    localparam int RUN_CYCLES     = RST_CYCLES + LOCK_CYCLES + CAL_CYCLES + 20 + RAND_CYCLES
                                    + (NUM_PS_MOVES + 1) * (PS_MOVE_LIMIT + 2)
                                    + 3 * (CAL_CYCLES + 10) + NRST_CYCLES;

    logic      clk_div;
    logic      rst_in;
    logic      ddr_rst;
    logic      dly_rst;
    logic      dci_rst;
    logic      ld_delay;
    logic      set;
    dly_data_t dly_data;
    dly_addr_t dly_addr;
    dly_addr_t dly_rd_addr;
    logic      ddr3_nrst;
    logic      locked;
    logic      ps_rdy;
    logic [PHASE_WIDTH-1:0] ps_out;
    dly_data_t dly_rd;

    dly_data_t pend_m [NUM_DLY];             // model of staged delays
    dly_data_t act_m  [NUM_DLY];             // model of applied delays
    logic signed [PHASE_WIDTH-1:0] phase_m;  // model phase
    int seed    = 22257;

    initial clk_div = 1'b0;
    always #(CLK_PERIOD / 2) clk_div = ~clk_div;

    ddr3_phy_ctrl #(
        .NUM_GROUPS(NUM_GROUPS), .PHASE_WIDTH(PHASE_WIDTH), .PS_STEP_CYCLES(PS_STEP_CYCLES),
        .LOCK_CYCLES(LOCK_CYCLES), .CAL_CYCLES(CAL_CYCLES)
    ) uut (
        .clk_div_i(clk_div), .rst_in(rst_in), .ddr_rst_i(ddr_rst), .dly_rst_i(dly_rst),
        .dci_rst_i(dci_rst), .dly_data_i(dly_data), .dly_addr_i(dly_addr),
        .ld_delay_i(ld_delay), .set_i(set), .dly_rd_addr_i(dly_rd_addr),
        .ddr3_nrst_o(ddr3_nrst), .locked_o(locked), .ps_rdy_o(ps_rdy),
        .ps_out_o(ps_out), .dly_rd_o(dly_rd)
    );

    task automatic abort_run(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input dly_data_t exp, input dly_data_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            abort_run("delay read-back mismatch");
        end
    endtask

    task automatic check_phase(input string name, input logic [PHASE_WIDTH-1:0] exp,
                               input logic [PHASE_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            abort_run("phase output mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            abort_run("control bit mismatch");
        end
    endtask

    task automatic next_edge();
        @(posedge clk_div);
        #2;    // drive and sample point
    endtask

    // one bank cycle whose read-back shows the active state from before this edge
    task automatic bank_cycle(input string name, input logic ld, input dly_addr_t addr,
                              input dly_data_t data, input logic st, input dly_addr_t rd_addr);
        dly_data_t exp_rd;
        exp_rd = (rd_addr[DLY_ADDR_W-1:DLY_GROUP_LSB] < NUM_GROUPS) ? act_m[rd_addr] : '0;
        ld_delay    = ld;
        dly_addr    = addr;
        dly_data    = data;
        set         = st;
        dly_rd_addr = rd_addr;
        if (st) begin
            for (int i = 0; i < NUM_DLY; i++) begin
                act_m[i] = pend_m[i];    // old pending
            end
        end
        if (ld && (addr[DLY_ADDR_W-1:DLY_GROUP_LSB] < NUM_GROUPS)) begin
            pend_m[addr] = data;    // group-major so the address is the index
        end
        next_edge();
        ld_delay = 1'b0;
        set      = 1'b0;
        check_data(name, exp_rd, dly_rd);
    endtask

    // load a phase target, try a dropped load mid-move, wait for ready
    task automatic phase_move(input string name, input dly_data_t tgt);
        logic signed [PHASE_WIDTH-1:0] tgt_s;
        int n;
        tgt_s    = PHASE_WIDTH'(signed'(tgt));
        ld_delay = 1'b1;
        dly_addr = PS_ADDR;
        dly_data = tgt;
        next_edge();
        ld_delay = 1'b0;
        check_bit(name, tgt_s == phase_m, ps_rdy);    // low only if it must move
        if (tgt_s != phase_m) begin
            ld_delay = 1'b1;
            dly_data = tgt ^ 8'h0f;    // dropped while busy
            next_edge();
            ld_delay = 1'b0;
            n = 1;
            while (!ps_rdy && n < PS_MOVE_LIMIT) begin
                next_edge();
                n++;
            end
            if (!ps_rdy) abort_run("phase shift did not return ready in time");
            phase_m = tgt_s;
        end
        check_phase(name, phase_m, ps_out);
    endtask

    // reset request pulse, then follow locked for a number of edges
    task automatic recal_check(input string name, input logic by_dci, input int edges);
        dly_rst = !by_dci;
        dci_rst = by_dci;
        next_edge();
        dly_rst = 1'b0;
        dci_rst = 1'b0;
        check_bit(name, 1'b0, locked);
        for (int n = 2; n <= edges; n++) begin
            next_edge();
            check_bit(name, n >= CAL_CYCLES + 1, locked);
        end
    endtask

    initial begin
        dly_addr_t r_addr;
        {rst_in, ddr_rst, dly_rst, dci_rst, ld_delay, set} = 6'b100000;
        dly_data    = '0;
        dly_addr    = '0;
        dly_rd_addr = '0;
        phase_m     = '0;
        for (int i = 0; i < NUM_DLY; i++) begin
            pend_m[i] = '0;
            act_m[i]  = '0;
        end
        repeat (RST_CYCLES) next_edge();
        check_bit("reset_locked", 1'b0, locked);
        check_bit("reset_ps_rdy", 1'b1, ps_rdy);
        check_data("reset_read", 8'h00, dly_rd);
        rst_in = 1'b0;
        for (int n = 1; n <= LOCK_CYCLES + CAL_CYCLES + 2; n++) begin
            next_edge();
            check_bit("startup_lock", n == LOCK_CYCLES + CAL_CYCLES + 2, locked);
        end
        bank_cycle("ld_no_set", 1'b1, 7'h05, 8'ha5, 1'b0, 7'h05);
        bank_cycle("ld_no_set", 1'b1, 7'h25, 8'h3c, 1'b0, 7'h05);
        bank_cycle("ld_no_set", 1'b1, 7'h45, 8'h7e, 1'b0, 7'h25);
        bank_cycle("set_with_ld", 1'b1, 7'h05, 8'h11, 1'b1, 7'h45);    // 0x11 stays pending
        bank_cycle("after_set", 1'b0, 7'h00, 8'h00, 1'b0, 7'h05);
        bank_cycle("after_set", 1'b0, 7'h00, 8'h00, 1'b0, 7'h25);
        bank_cycle("after_set", 1'b0, 7'h00, 8'h00, 1'b1, 7'h45);
        bank_cycle("second_set", 1'b0, 7'h00, 8'h00, 1'b0, 7'h05);
        bank_cycle("second_set", 1'b0, 7'h00, 8'h00, 1'b0, 7'h05);
        for (int n = 0; n < RAND_CYCLES; n++) begin
            r_addr = dly_addr_t'($random(seed));
            if (r_addr == PS_ADDR) r_addr = PS_ADDR | 7'h01;    // keep the phase idle
            bank_cycle("random_bank", 1'($random(seed)), r_addr, dly_data_t'($random(seed)),
                       (($random(seed) & 3) == 0), dly_addr_t'($random(seed)));
        end
        for (int n = 0; n < NUM_PS_MOVES; n++) begin
            phase_move("phase_random", dly_data_t'($random(seed) % 21));
        end
        phase_move("phase_same", dly_data_t'(phase_m));
        check_bit("recal_start", 1'b1, locked);
        recal_check("recal_dly", 1'b0, CAL_CYCLES + 4);
        recal_check("recal_dci", 1'b1, 10);
        recal_check("recal_in_cal", 1'b0, CAL_CYCLES + 4);
        for (int n = 0; n < NRST_CYCLES; n++) begin
            ddr_rst = 1'($random(seed));
            #1;
            check_bit("nrst_invert", !ddr_rst, ddr3_nrst);
            next_edge();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD + 200 * CLK_PERIOD);
        abort_run("watchdog expired before the tests completed");
    end

endmodule : tb_ddr3_phy_ctrl

`default_nettype wire

/* vlog.f */
logic/phy_ctrl_pkg.sv
logic/dly_prog_if.sv
logic/delay_bank.sv
logic/phase_shift_cntr.sv
logic/startup_fsm.sv
logic/ddr3_phy_ctrl.sv
verif/phy_ctrl_asserts.sv
verif/tb_ddr3_phy_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_ddr3_phy_ctrl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the simulator exit status is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
